//--- all.f
hdl/axil_single_pkg.sv
hdl/resp_fifo.sv
hdl/axil_single_write.sv
hdl/axil_single_read.sv
hdl/axil_single.sv
testbench/axil_single_checker.sv
testbench/tb_axil_single.sv

//--- hdl/axil_single.sv
// AXI-lite front end serving NS single-register slaves through one-hot strobes
`timescale 1ns/10ps
`default_nettype none

module axil_single #(
	parameter int NS = 12,
	parameter int LGFLEN = 3,
	localparam int IW = (NS > 1) ? $clog2(NS) : 1,
	localparam int AW = IW + axil_single_pkg::ADDR_LSBS
) (
	input  wire					S_AXI_ACLK,
	input  wire					S_AXI_ARESETN,
	// Write address, data and response
	input  wire					i_awvalid,
	output logic					o_awready,
	input  wire [AW-1:0]				i_awaddr,
	input  wire axil_single_pkg::axi_prot_t		i_awprot,
	input  wire					i_wvalid,
	output logic					o_wready,
	input  wire axil_single_pkg::axi_data_t		i_wdata,
	input  wire axil_single_pkg::axi_strb_t		i_wstrb,
	output logic					o_bvalid,
	input  wire					i_bready,
	output axil_single_pkg::axi_resp_t		o_bresp,
	// Read address and data
	input  wire					i_arvalid,
	output logic					o_arready,
	input  wire [AW-1:0]				i_araddr,
	input  wire axil_single_pkg::axi_prot_t		i_arprot,
	output logic					o_rvalid,
	input  wire					i_rready,
	output axil_single_pkg::axi_data_t		o_rdata,
	output axil_single_pkg::axi_resp_t		o_rresp,
	// Slave side, flattened per slave
	output logic [NS-1:0]				o_m_awvalid,
	output axil_single_pkg::axi_prot_t		o_m_awprot,
	output axil_single_pkg::axi_data_t		o_m_wdata,
	output axil_single_pkg::axi_strb_t		o_m_wstrb,
	input  wire [2*NS-1:0]				i_m_bresp,
	output logic [NS-1:0]				o_m_arvalid,
	output axil_single_pkg::axi_prot_t		o_m_arprot,
	input  wire [NS*axil_single_pkg::DATA_WIDTH-1:0]	i_m_rdata,
	input  wire [2*NS-1:0]				i_m_rresp
);

	// Write and read paths run independently
	axil_single_write #(
		.NS(NS),
		.LGFLEN(LGFLEN)
	) u_write (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_awvalid, .o_awready, .i_awaddr, .i_awprot,
		.i_wvalid, .o_wready, .i_wdata, .i_wstrb,
		.o_bvalid, .i_bready, .o_bresp,
		.o_m_awvalid, .o_m_awprot, .o_m_wdata, .o_m_wstrb,
		.i_m_bresp
	);

	axil_single_read #(
		.NS(NS),
		.LGFLEN(LGFLEN)
	) u_read (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_arvalid, .o_arready, .i_araddr, .i_arprot,
		.o_rvalid, .i_rready, .o_rdata, .o_rresp,
		.o_m_arvalid, .o_m_arprot,
		.i_m_rdata, .i_m_rresp
	);

endmodule

`default_nettype wire

//--- hdl/axil_single_pkg.sv
// Shared widths, vector types and response codes for the single-register AXI-lite front end
`default_nettype none

package axil_single_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////

	// Data bus width, one word per slave
	localparam int DATA_WIDTH = 32;
	// One strobe bit per byte lane
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	// Byte offset bits, ignored by the index decode
	localparam int ADDR_LSBS = 2;

	//////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////

	// Write data and read data, both sides
	typedef logic [DATA_WIDTH-1:0] axi_data_t;
	typedef logic [STRB_WIDTH-1:0] axi_strb_t;
	typedef logic [1:0] axi_resp_t;
	typedef logic [2:0] axi_prot_t;

	// Response encodings
	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;
	// DECERR, returned for an index with no slave behind it
	localparam axi_resp_t RESP_INTERCONNECT_ERR = 2'b11;

endpackage

`default_nettype wire

//--- hdl/axil_single_read.sv
// AXI-lite read path with AR acceptance, one-hot slave read strobe and queued R data
`timescale 1ns/10ps
`default_nettype none

module axil_single_read #(
	parameter int NS = 12,
	parameter int LGFLEN = 3,
	localparam int IW = (NS > 1) ? $clog2(NS) : 1,
	localparam int AW = IW + axil_single_pkg::ADDR_LSBS
) (
	input  wire					S_AXI_ACLK,
	input  wire					S_AXI_ARESETN,
	// Upstream AR and R channels
	input  wire					i_arvalid,
	output logic					o_arready,
	input  wire [AW-1:0]				i_araddr,
	input  wire axil_single_pkg::axi_prot_t		i_arprot,
	output logic					o_rvalid,
	input  wire					i_rready,
	output axil_single_pkg::axi_data_t		o_rdata,
	output axil_single_pkg::axi_resp_t		o_rresp,
	// Slave side
	output logic [NS-1:0]				o_m_arvalid,
	output axil_single_pkg::axi_prot_t		o_m_arprot,
	input  wire [NS*axil_single_pkg::DATA_WIDTH-1:0]	i_m_rdata,
	input  wire [2*NS-1:0]				i_m_rresp
);

	import axil_single_pkg::*;

	// Queue entry holds data above response
	localparam int RW = DATA_WIDTH + $bits(axi_resp_t);

	logic			ar_xfer;
	logic			r_xfer;
	logic [NS-1:0]		arsel_r;
	axi_prot_t		arprot_r;
	logic [IW-1:0]		rindex0_r;
	logic [IW-1:0]		rindex1_r;
	logic			rstage0_r;
	logic			rstage1_r;
	logic			rstage2_r;
	axi_data_t		rdata_sel;
	axi_data_t		rdata_r;
	axi_resp_t		rresp_sel;
	axi_resp_t		rresp_r;
	logic [LGFLEN:0]	rcount_r;
	logic [RW-1:0]		rfifo_out;
	logic			rempty;

	//////////////////////////////////////////////////////////////////////
	// AR acceptance and strobe
	//////////////////////////////////////////////////////////////////////

	assign o_arready = !rcount_r[LGFLEN];
	assign ar_xfer = i_arvalid && o_arready;
	assign r_xfer = o_rvalid && i_rready;

	// Strobe lasts one cycle per accepted read
	// Valid bits walk strobe, sample and push stages
	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
		begin
			arsel_r <= '0;
			rstage0_r <= 1'b0;
			rstage1_r <= 1'b0;
			rstage2_r <= 1'b0;
		end
		else
		begin
			arsel_r <= ar_xfer ? (NS'(1) << i_araddr[AW-1:ADDR_LSBS]) : '0;
			rstage0_r <= ar_xfer;
			rstage1_r <= rstage0_r;
			rstage2_r <= rstage1_r;
		end

	always_ff @(posedge S_AXI_ACLK)
		if (ar_xfer)
		begin
			rindex0_r <= i_araddr[AW-1:ADDR_LSBS];
			arprot_r <= i_arprot;
		end

	assign o_m_arvalid = arsel_r;
	assign o_m_arprot = arprot_r;

	//////////////////////////////////////////////////////////////////////
	// Data capture and R queue
	//////////////////////////////////////////////////////////////////////

	// Zero data and DECERR for an empty slot
	always_comb
	begin
		rdata_sel = '0;
		rresp_sel = RESP_INTERCONNECT_ERR;
		for (int i = 0; i < NS; i++)
			if (rindex1_r == IW'(i))
			begin
				rdata_sel = i_m_rdata[DATA_WIDTH*i +: DATA_WIDTH];
				rresp_sel = i_m_rresp[2*i +: 2];
			end
	end

	// Index trails the strobe by one stage, lining up with slave data
	always_ff @(posedge S_AXI_ACLK)
	begin
		rindex1_r <= rindex0_r;
		rdata_r <= rdata_sel;
		rresp_r <= rresp_sel;
	end

	// Outstanding reads, from AR accept to R handshake
	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
			rcount_r <= '0;
		else
			case ({ar_xfer, r_xfer})
			2'b10: rcount_r <= rcount_r + 1'b1;
			2'b01: rcount_r <= rcount_r - 1'b1;
			default: rcount_r <= rcount_r;
			endcase

	resp_fifo #(
		.WIDTH(RW),
		.LGFLEN(LGFLEN)
	) u_rfifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr(rstage2_r),
		.i_data({rdata_r, rresp_r}),
		.i_rd(r_xfer),
		.o_data(rfifo_out),
		.o_empty(rempty)
	);

	assign o_rvalid = !rempty;
	assign o_rdata = rfifo_out[RW-1:2];
	assign o_rresp = rfifo_out[1:0];

endmodule

`default_nettype wire

//--- hdl/axil_single_write.sv
// AXI-lite write path with AW/W acceptance, one-hot slave write strobe and queued B response
`timescale 1ns/10ps
`default_nettype none

module axil_single_write #(
	parameter int NS = 12,
	parameter int LGFLEN = 3,
	localparam int IW = (NS > 1) ? $clog2(NS) : 1,
	localparam int AW = IW + axil_single_pkg::ADDR_LSBS
) (
	input  wire				S_AXI_ACLK,
	input  wire				S_AXI_ARESETN,
	// Upstream AW, W and B channels
	input  wire				i_awvalid,
	output logic				o_awready,
	input  wire [AW-1:0]			i_awaddr,
	input  wire axil_single_pkg::axi_prot_t	i_awprot,
	input  wire				i_wvalid,
	output logic				o_wready,
	input  wire axil_single_pkg::axi_data_t	i_wdata,
	input  wire axil_single_pkg::axi_strb_t	i_wstrb,
	output logic				o_bvalid,
	input  wire				i_bready,
	output axil_single_pkg::axi_resp_t	o_bresp,
	// Slave side
	output logic [NS-1:0]			o_m_awvalid,
	output axil_single_pkg::axi_prot_t	o_m_awprot,
	output axil_single_pkg::axi_data_t	o_m_wdata,
	output axil_single_pkg::axi_strb_t	o_m_wstrb,
	input  wire [2*NS-1:0]			i_m_bresp
);

	import axil_single_pkg::*;

	logic			aw_xfer;
	logic			w_xfer;
	logic			b_xfer;
	logic			wready_r;
	logic [NS-1:0]		awsel_r;
	logic [IW-1:0]		windex_r;
	axi_prot_t		awprot_r;
	logic [IW-1:0]		bindex_r;
	logic			bstage0_r;
	logic			bstage1_r;
	axi_resp_t		bresp_sel;
	axi_resp_t		bresp_r;
	logic [LGFLEN:0]	wcount_r;
	logic			bempty;

	//////////////////////////////////////////////////////////////////////
	// AW and W acceptance
	//////////////////////////////////////////////////////////////////////

	// Take a new address once the pending one meets its data, count not full
	assign o_awready = (!wready_r || i_wvalid) && !wcount_r[LGFLEN];
	assign aw_xfer = i_awvalid && o_awready;
	assign w_xfer = i_wvalid && wready_r;
	assign b_xfer = o_bvalid && i_bready;

	// One-hot select held until the W beat; out of range decodes to zero
	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
		begin
			wready_r <= 1'b0;
			awsel_r <= '0;
		end
		else if (aw_xfer)
		begin
			wready_r <= 1'b1;
			awsel_r <= NS'(1) << i_awaddr[AW-1:ADDR_LSBS];
		end
		else if (i_wvalid)
		begin
			wready_r <= 1'b0;
			awsel_r <= '0;
		end

	always_ff @(posedge S_AXI_ACLK)
		if (aw_xfer)
		begin
			windex_r <= i_awaddr[AW-1:ADDR_LSBS];
			awprot_r <= i_awprot;
		end

	// Slave writes in the W transfer cycle
	assign o_wready = wready_r;
	assign o_m_awvalid = i_wvalid ? awsel_r : '0;
	assign o_m_awprot = awprot_r;
	assign o_m_wdata = i_wdata;
	assign o_m_wstrb = i_wstrb;

	//////////////////////////////////////////////////////////////////////
	// Response capture
	//////////////////////////////////////////////////////////////////////

	// Stage 0 marks the W beat, stage 1 pushes the sampled response
	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
		begin
			bstage0_r <= 1'b0;
			bstage1_r <= 1'b0;
		end
		else
		begin
			bstage0_r <= w_xfer;
			bstage1_r <= bstage0_r;
		end

	// Pick the addressed slave's response, DECERR when there is none
	always_comb
	begin
		bresp_sel = RESP_INTERCONNECT_ERR;
		for (int i = 0; i < NS; i++)
			if (bindex_r == IW'(i))
				bresp_sel = i_m_bresp[2*i +: 2];
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		bindex_r <= windex_r;
		bresp_r <= bresp_sel;
	end

	// Outstanding writes, from AW accept to B handshake
	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
			wcount_r <= '0;
		else
			case ({aw_xfer, b_xfer})
			2'b10: wcount_r <= wcount_r + 1'b1;
			2'b01: wcount_r <= wcount_r - 1'b1;
			default: wcount_r <= wcount_r;
			endcase

	// B queue, cannot overflow while the count gates AW
	resp_fifo #(
		.WIDTH($bits(axi_resp_t)),
		.LGFLEN(LGFLEN)
	) u_bfifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr(bstage1_r),
		.i_data(bresp_r),
		.i_rd(b_xfer),
		.o_data(o_bresp),
		.o_empty(bempty)
	);

	assign o_bvalid = !bempty;

endmodule

`default_nettype wire

//--- hdl/resp_fifo.sv
// Synchronous response FIFO with a registered read port, sized by width and log2 depth
`timescale 1ns/10ps
`default_nettype none

module resp_fifo #(
	parameter int WIDTH = 2,
	parameter int LGFLEN = 3
) (
	input  wire			S_AXI_ACLK,
	input  wire			S_AXI_ARESETN,
	input  wire			i_wr,
	input  wire [WIDTH-1:0]		i_data,
	input  wire			i_rd,
	output logic [WIDTH-1:0]	o_data,
	output logic			o_empty
);

	// Storage array, 2^LGFLEN entries
	logic [WIDTH-1:0]	mem [0:(1<<LGFLEN)-1];
	// Pointers carry one extra bit so a full queue differs from an empty one
	logic [LGFLEN:0]	wr_ptr;
	logic [LGFLEN:0]	rd_ptr;
	logic [LGFLEN:0]	rd_next;
	logic			pop;

	// Only pop what is actually presented
	assign pop = i_rd && !o_empty;
	assign rd_next = rd_ptr + (LGFLEN+1)'(pop);

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
		if (i_wr)
			mem[wr_ptr[LGFLEN-1:0]] <= i_data;

	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
			wr_ptr <= '0;
		else if (i_wr)
			wr_ptr <= wr_ptr + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
			rd_ptr <= '0;
		else
			rd_ptr <= rd_next;

	// Compared against the old write pointer
	// A new entry shows up one cycle after it is written
	always_ff @(posedge S_AXI_ACLK)
		if (!S_AXI_ARESETN)
			o_empty <= 1'b1;
		else
			o_empty <= (rd_next == wr_ptr);

	// Registered head of queue, follows the pointer after any pop
	always_ff @(posedge S_AXI_ACLK)
		o_data <= mem[rd_next[LGFLEN-1:0]];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_axil_single -f all.f -o tb_axil_single \
	&& ./obj_dir/tb_axil_single > sim.log 2>&1
grep -qx "Result: PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/axil_single_checker.sv
// Bound assertions for one-hot slave strobes and the B and R hold rules of the AXI-lite front end
`timescale 1ns/10ps
`default_nettype none

module axil_single_checker #(
	parameter int NS = 12
) (
	input  wire					S_AXI_ACLK,
	input  wire					S_AXI_ARESETN,
	input  wire [NS-1:0]				i_m_awvalid,
	input  wire [NS-1:0]				i_m_arvalid,
	input  wire					i_bvalid,
	input  wire					i_bready,
	input  wire axil_single_pkg::axi_resp_t		i_bresp,
	input  wire					i_rvalid,
	input  wire					i_rready,
	input  wire axil_single_pkg::axi_data_t		i_rdata,
	input  wire axil_single_pkg::axi_resp_t		i_rresp
);

	//////////////////////////////////////////////////////////////////////
	// Slave strobes never select two slaves
	//////////////////////////////////////////////////////////////////////

	a_aw_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(i_m_awvalid))
		else $error("Write strobe selects more than one slave");

	a_ar_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(i_m_arvalid))
		else $error("Read strobe selects more than one slave");

	//////////////////////////////////////////////////////////////////////
	// Stalled responses stay put
	//////////////////////////////////////////////////////////////////////

	a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
		else $error("Write response dropped or changed while stalled");

	// Data and response both held
	a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
		else $error("Read response dropped or changed while stalled");

endmodule

`default_nettype wire

//--- testbench/tb_axil_single.sv
// Testbench for the AXI-lite single-register front end with twelve slave register models
`timescale 1ns/10ps
`default_nettype none

module tb_axil_single;

	import axil_single_pkg::*;

	localparam int NS = 12;
	localparam int LGFLEN = 3;
	localparam int MAXOPS = 64;

	logic			S_AXI_ACLK;
	logic			S_AXI_ARESETN;
	logic			awvalid;
	logic			awready;
	logic [5:0]		awaddr;
	axi_prot_t		awprot;
	logic			wvalid;
	logic			wready;
	axi_data_t		wdata;
	axi_strb_t		wstrb;
	logic			bvalid;
	logic			bready;
	axi_resp_t		bresp;
	logic			arvalid;
	logic			arready;
	logic [5:0]		araddr;
	axi_prot_t		arprot;
	logic			rvalid;
	logic			rready;
	axi_data_t		rdata;
	axi_resp_t		rresp;
	logic [NS-1:0]		m_awvalid;
	axi_prot_t		m_awprot;
	axi_data_t		m_wdata;
	axi_strb_t		m_wstrb;
	logic [2*NS-1:0]	m_bresp;
	logic [NS-1:0]		m_arvalid;
	axi_prot_t		m_arprot;
	logic [NS*DATA_WIDTH-1:0]	m_rdata;
	logic [2*NS-1:0]	m_rresp;

	// Slave registers, their read latches and the reference copy
	axi_data_t		slave_reg [NS];
	axi_data_t		slave_rdata [NS];
	axi_data_t		ref_reg [NS];

	// Stimulus table
	logic			op_write [MAXOPS];
	logic [3:0]		op_index [MAXOPS];
	axi_data_t		op_data [MAXOPS];
	axi_strb_t		op_strb [MAXOPS];
	axi_resp_t		op_resp [MAXOPS];
	axi_data_t		op_rdata [MAXOPS];
	int			n_ops;
	logic			built;

	// Responses still owed, oldest first
	axi_resp_t		exp_bresp [$];
	axi_data_t		exp_rdata [$];
	axi_resp_t		exp_rresp [$];
	// Read strobes still owed, with their protection bits
	axi_prot_t		exp_arprot [$];

	int			errors;
	int			checks;
	logic [31:0]		rng_state;
	logic			hold_rready;

	axil_single #(
		.NS(NS),
		.LGFLEN(LGFLEN)
	) dut (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr), .i_awprot(awprot),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr), .i_arprot(arprot),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
		.o_m_awvalid(m_awvalid), .o_m_awprot(m_awprot), .o_m_wdata(m_wdata),
		.o_m_wstrb(m_wstrb), .i_m_bresp(m_bresp),
		.o_m_arvalid(m_arvalid), .o_m_arprot(m_arprot),
		.i_m_rdata(m_rdata), .i_m_rresp(m_rresp)
	);

	bind axil_single axil_single_checker #(.NS(NS)) u_checker (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_m_awvalid(o_m_awvalid), .i_m_arvalid(o_m_arvalid),
		.i_bvalid(o_bvalid), .i_bready(i_bready), .i_bresp(o_bresp),
		.i_rvalid(o_rvalid), .i_rready(i_rready), .i_rdata(o_rdata), .i_rresp(o_rresp)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Byte lanes with a strobe bit take the new data
	function automatic axi_data_t merge_bytes(input axi_data_t old, input axi_data_t din,
		input axi_strb_t strb);
		axi_data_t res;
		res = old;
		for (int b = 0; b < STRB_WIDTH; b++)
			if (strb[b])
				res[8*b +: 8] = din[8*b +: 8];
		return res;
	endfunction

	// No slave above NS-1, slave 5 always refuses
	function automatic axi_resp_t expected_resp(input logic [3:0] idx);
		if (int'(idx) >= NS)
			return RESP_INTERCONNECT_ERR;
		if (int'(idx) == 5)
			return RESP_SLVERR;
		return RESP_OKAY;
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Append one entry and advance the reference registers
	task automatic add_op(input logic wr, input int idx, input axi_data_t data,
		input axi_strb_t strb);
		logic [3:0] ix;
		ix = 4'(idx);
		op_write[n_ops] = wr;
		op_index[n_ops] = ix;
		op_data[n_ops] = data;
		op_strb[n_ops] = strb;
		op_resp[n_ops] = expected_resp(ix);
		if (wr && idx < NS)
			ref_reg[idx] = merge_bytes(ref_reg[idx], data, strb);
		op_rdata[n_ops] = (idx < NS) ? ref_reg[idx] : '0;
		n_ops++;
	endtask

	task automatic build_table;
		for (int s = 0; s < NS; s++)
		begin
			rng_state = xorshift32(rng_state);
			add_op(1'b1, s, rng_state, 4'hf);
			add_op(1'b0, s, '0, '0);
		end
		// Partial strobes
		add_op(1'b1, 2, 32'ha5a5_5a5a, 4'b0101);
		add_op(1'b0, 2, '0, '0);
		add_op(1'b1, 7, 32'h1234_5678, 4'b1000);
		add_op(1'b0, 7, '0, '0);
		// Empty slots 12 to 15
		for (int s = NS; s < 16; s++)
		begin
			add_op(1'b1, s, 32'hdead_0000 + 32'(s), 4'hf);
			add_op(1'b0, s, '0, '0);
		end
		// Readback after the empty slot writes
		for (int s = 0; s < NS; s++)
			add_op(1'b0, s, '0, '0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Slave models
	//////////////////////////////////////////////////////////////////////

	// Write in the strobe cycle, read data valid the cycle after
	always @(posedge S_AXI_ACLK)
		for (int s = 0; s < NS; s++)
		begin
			if (m_awvalid[s])
				slave_reg[s] <= merge_bytes(slave_reg[s], m_wdata, m_wstrb);
			if (m_arvalid[s])
				slave_rdata[s] <= slave_reg[s];
		end

	always_comb
		for (int s = 0; s < NS; s++)
		begin
			m_rdata[DATA_WIDTH*s +: DATA_WIDTH] = slave_rdata[s];
			m_bresp[2*s +: 2] = (s == 5) ? RESP_SLVERR : RESP_OKAY;
			m_rresp[2*s +: 2] = (s == 5) ? RESP_SLVERR : RESP_OKAY;
		end

	// Protection bits ride along with every slave strobe
	always @(posedge S_AXI_ACLK)
		if (S_AXI_ARESETN)
		begin
			if (m_awvalid != '0)
				compare("m_awprot", 32'(m_awprot), 32'(awprot));
			if (m_arvalid != '0)
			begin
				if (exp_arprot.size() == 0)
				begin
					errors++;
					$display("Error at %0t ns: read strobe with no read outstanding", $time);
				end
				else
					compare("m_arprot", 32'(m_arprot), 32'(exp_arprot.pop_front()));
			end
		end

	//////////////////////////////////////////////////////////////////////
	// Request drivers
	//////////////////////////////////////////////////////////////////////

	// AW and W raised together, each dropped after its own handshake
	task automatic issue_write(input int k);
		logic aw_done;
		logic w_done;
		logic aw_hs;
		logic w_hs;
		aw_done = 1'b0;
		w_done = 1'b0;
		awaddr = {op_index[k], 2'b00};
		awprot = 3'(k);
		wdata = op_data[k];
		wstrb = op_strb[k];
		awvalid = 1'b1;
		wvalid = 1'b1;
		exp_bresp.push_back(op_resp[k]);
		while (!(aw_done && w_done))
		begin
			@(negedge S_AXI_ACLK);
			aw_hs = awvalid && awready;
			w_hs = wvalid && wready;
			@(posedge S_AXI_ACLK);
			#1;
			if (aw_hs)
			begin
				awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_hs)
			begin
				wvalid = 1'b0;
				w_done = 1'b1;
			end
		end
	endtask

	task automatic issue_read(input int k);
		logic hs;
		araddr = {op_index[k], 2'b00};
		arprot = 3'(k);
		arvalid = 1'b1;
		exp_rdata.push_back(op_rdata[k]);
		exp_rresp.push_back(op_resp[k]);
		// Empty slots raise no strobe
		if (int'(op_index[k]) < NS)
			exp_arprot.push_back(3'(k));
		do
		begin
			@(negedge S_AXI_ACLK);
			hs = arready;
			@(posedge S_AXI_ACLK);
			#1;
		end
		while (!hs);
		arvalid = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Response side
	//////////////////////////////////////////////////////////////////////

	// Handshakes seen mid-cycle, ready toggled just after the edge
	initial
	begin
		forever
		begin
			@(negedge S_AXI_ACLK);
			if (S_AXI_ARESETN && bvalid && bready)
			begin
				if (exp_bresp.size() == 0)
				begin
					errors++;
					$display("Error at %0t ns: write response with no write outstanding", $time);
				end
				else
					compare("bresp", 32'(bresp), 32'(exp_bresp.pop_front()));
			end
			if (S_AXI_ARESETN && rvalid && rready)
			begin
				if (exp_rdata.size() == 0)
				begin
					errors++;
					$display("Error at %0t ns: read response with no read outstanding", $time);
				end
				else
				begin
					compare("rdata", rdata, exp_rdata.pop_front());
					compare("rresp", 32'(rresp), 32'(exp_rresp.pop_front()));
				end
			end
			@(posedge S_AXI_ACLK);
			#1;
			rng_state = xorshift32(rng_state);
			bready = rng_state[3];
			rready = rng_state[9] && !hold_rready;
		end
	end

	// Budget of 40 cycles per table entry
	initial
	begin
		wait (built);
		repeat (n_ops * 40) @(posedge S_AXI_ACLK);
		$display("Error: timed out after %0d cycles with responses still missing", n_ops * 40);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Result: FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int accepted;
		S_AXI_ARESETN = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		awprot = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		arprot = '0;
		rready = 1'b0;
		hold_rready = 1'b0;
		errors = 0;
		checks = 0;
		n_ops = 0;
		built = 1'b0;
		rng_state = 32'd61;
		for (int s = 0; s < NS; s++)
		begin
			slave_reg[s] = 32'(s) * 32'h0101_0101;
			ref_reg[s] = 32'(s) * 32'h0101_0101;
			slave_rdata[s] = '0;
		end
		build_table();
		built = 1'b1;

		repeat (2) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// Table in order, back to back
		for (int k = 0; k < n_ops; k++)
			if (op_write[k])
				issue_write(k);
			else
				issue_read(k);
		while (exp_bresp.size() != 0 || exp_rdata.size() != 0)
			@(posedge S_AXI_ACLK);

		// Fill the read count with R stalled
		hold_rready = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		accepted = 0;
		araddr = '0;
		arvalid = 1'b1;
		for (int c = 0; c < 16; c++)
		begin
			@(negedge S_AXI_ACLK);
			if (arready)
			begin
				accepted++;
				exp_rdata.push_back(ref_reg[0]);
				exp_rresp.push_back(RESP_OKAY);
				exp_arprot.push_back(arprot);
			end
			@(posedge S_AXI_ACLK);
			#1;
		end
		arvalid = 1'b0;
		compare("reads accepted with rready low", 32'(accepted), 32'(1 << LGFLEN));
		compare("arready with read count full", 32'(arready), 32'd0);
		hold_rready = 1'b0;
		while (exp_rdata.size() != 0)
			@(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		compare("arready after drain", 32'(arready), 32'd1);
		compare("read strobes never seen", 32'(exp_arprot.size()), 32'd0);

		// Untouched by the empty slot writes
		for (int s = 0; s < NS; s++)
			compare("slave register", slave_reg[s], ref_reg[s]);
		repeat (4) @(posedge S_AXI_ACLK);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
